/* Bender.yml */
package:
  name: lcd_text

sources:
  # package first, then the RTL leaves and the top level
  - design/lcd_pkg.sv
  - design/char_buffer.sv
  - design/write_arbiter.sv
  - design/hex_formatter.sv
  - design/lcd1602.sv
  - design/lcd_text_top.sv

  - target: simulation
    files:
      - tb/lcd_text_tb.sv

# top modules: lcd_text_top (RTL), lcd_text_tb (testbench)

/* design/char_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module char_buffer (
	input  logic           clk,
	input  logic           rst,
	input  logic           we,
	input  lcd_pkg::addr_t addr,
	input  lcd_pkg::char_t wr_char,
	output lcd_pkg::row_t  row_1,
	output lcd_pkg::row_t  row_2
);
	import lcd_pkg::*;

	char_t mem [buf_depth];

	////////////////////////////////////////////////////////////////////////////
	// storage
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst) begin
			for (int i = 0; i < buf_depth; i++) begin
				mem[i] <= blank_char;             // screen comes up blank.
			end
		end else if (we) begin
			mem[addr] <= wr_char;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// row words for the driver
	////////////////////////////////////////////////////////////////////////////

	// column 0 lands in bits 127:120, column 15 in bits 7:0
	always_comb begin
		for (int i = 0; i < lcd_cols; i++) begin
			row_1[(lcd_cols - 1 - i) * 8 +: 8] = mem[i];
			row_2[(lcd_cols - 1 - i) * 8 +: 8] = mem[lcd_cols + i];
		end
	end

	// a write must show up on its row word one cycle later
	a_write_visible: assert property (
		@(posedge clk) disable iff (!rst)
		we |=> ($past(addr) < addr_t'(lcd_cols))
			? (row_1[(lcd_cols - 1 - int'($past(addr))) * 8 +: 8] == $past(wr_char))
			: (row_2[(2 * lcd_cols - 1 - int'($past(addr))) * 8 +: 8] == $past(wr_char))
	);

endmodule

`default_nettype wire

/* design/hex_formatter.sv */
`timescale 1ns/1ps
`default_nettype none

module hex_formatter #(
	parameter int fmt_base = 24
) (
	input  logic           clk,
	input  logic           rst,
	input  logic           value_load,
	input  logic [31:0]    value,
	input  logic           fmt_gnt,
	output logic           value_busy,
	output logic           fmt_req,
	output lcd_pkg::addr_t fmt_addr,
	output lcd_pkg::char_t fmt_char
);
	import lcd_pkg::*;

	logic        busy;
	logic [31:0] value_q;
	logic [2:0]  digit;                        // 0 is the most significant nibble.
	logic [3:0]  nibble;

	function automatic char_t hex_ascii(input logic [3:0] n);
		if (n < 4'd10) begin
			return 8'h30 + 8'(n);             // '0'..'9'.
		end
		return 8'h37 + 8'(n);                 // 'A'..'F'.
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// digit sequencer
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst) begin
			busy <= 1'b0;
			digit <= 3'd0;
		end else if (!busy) begin
			if (value_load) begin
				busy <= 1'b1;
				digit <= 3'd0;
			end
		end else if (fmt_gnt) begin
			if (digit == 3'd7) begin
				busy <= 1'b0;                 // eighth digit taken.
			end
			digit <= digit + 3'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (value_load && !busy) begin
			value_q <= value;                 // loads while busy are dropped.
		end
	end

	assign nibble = value_q[{3'd7 - digit, 2'b00} +: 4];

	assign value_busy = busy;
	assign fmt_req = busy;
	assign fmt_addr = addr_t'(fmt_base) + addr_t'(digit);
	assign fmt_char = hex_ascii(nibble);

	// the digit window has to fit in the buffer
	a_addr_window: assert property (
		@(posedge clk) disable iff (!rst)
		fmt_req |-> (int'(fmt_addr) >= fmt_base) && (int'(fmt_addr) <= fmt_base + 7)
	);

endmodule

`default_nettype wire

/* design/lcd1602.sv */
`timescale 1ns/1ps
`default_nettype none

module lcd1602 #(
	parameter int clk_div = 24000
) (
	input  logic           clk,
	input  logic           rst,
	input  lcd_pkg::row_t  row_1,
	input  lcd_pkg::row_t  row_2,
	output logic           lcd_en,
	output logic           lcd_rw,
	output logic           lcd_rs,
	output lcd_pkg::char_t lcd_data
);
	import lcd_pkg::*;

	localparam int start_cycles = 10 * clk_div;
	localparam int start_w = $clog2(start_cycles + 1);
	localparam int div_w = $clog2(clk_div + 1);
	localparam int col_w = $clog2(lcd_cols);

	typedef enum logic [2:0] {
		st_idle,
		st_func,
		st_off,
		st_clear,
		st_entry,
		st_on,
		st_addr,
		st_char
	} state_t;

	logic [start_w-1:0] cnt_start;
	logic [div_w-1:0]   cnt_div;
	logic               delay_done;
	logic               byte_end;
	state_t             state;
	state_t             next_state;
	logic               row_sel;            // 0 row 1, 1 row 2.
	logic               next_row;
	logic [col_w-1:0]   col;
	logic [col_w-1:0]   next_col;
	row_t               row_word;
	char_t              next_data;

	////////////////////////////////////////////////////////////////////////////
	// start-up wait and byte period
	////////////////////////////////////////////////////////////////////////////

	assign delay_done = (cnt_start == start_w'(start_cycles - 1));

	always_ff @(posedge clk) begin
		if (!rst) begin
			cnt_start <= '0;
		end else if (!delay_done) begin
			cnt_start <= cnt_start + 1'b1;    // holds once the wait is over.
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			cnt_div <= '0;
		end else if (!delay_done || byte_end) begin
			cnt_div <= '0;
		end else begin
			cnt_div <= cnt_div + 1'b1;
		end
	end

	// high in the first half of each period, and through the whole wait
	assign lcd_en = (cnt_div <= div_w'((clk_div - 1) / 2));
	assign byte_end = delay_done && (cnt_div == div_w'(clk_div - 1));
	assign lcd_rw = 1'b0;                     // write only.

	////////////////////////////////////////////////////////////////////////////
	// command and refresh sequence
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		next_state = state;
		next_row = row_sel;
		next_col = col;
		case (state)
			st_idle:  next_state = st_func;
			st_func:  next_state = st_off;
			st_off:   next_state = st_clear;
			st_clear: next_state = st_entry;
			st_entry: next_state = st_on;
			st_on: begin
				next_state = st_addr;
				next_row = 1'b0;
			end
			st_addr: begin
				next_state = st_char;
				next_col = '0;
			end
			st_char: begin
				if (col == col_w'(lcd_cols - 1)) begin
					next_state = st_addr;
					next_row = ~row_sel;      // swap rows after column 15.
				end else begin
					next_col = col + 1'b1;
				end
			end
			default: next_state = st_idle;
		endcase
	end

	assign row_word = next_row ? row_2 : row_1;

	always_comb begin
		case (next_state)
			st_func:  next_data = cmd_function_set;
			st_off:   next_data = cmd_display_off;
			st_clear: next_data = cmd_clear;
			st_entry: next_data = cmd_entry_mode;
			st_on:    next_data = cmd_display_on;
			st_addr:  next_data = next_row ? cmd_row2_addr : cmd_row1_addr;
			st_char:  next_data = row_word[{col_w'(lcd_cols - 1) - next_col, 3'b000} +: 8];
			default:  next_data = 8'h00;
		endcase
	end

	// data and rs load at the last cycle of a period.
	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= st_idle;
			row_sel <= 1'b0;
			col <= '0;
			lcd_rs <= 1'b0;
			lcd_data <= 8'h00;
		end else if (byte_end) begin
			state <= next_state;
			row_sel <= next_row;
			col <= next_col;
			lcd_rs <= (next_state == st_char);
			lcd_data <= next_data;
		end
	end

	a_data_stable: assert property (
		@(posedge clk) disable iff (!rst)
		delay_done && lcd_en && $past(lcd_en) |-> $stable(lcd_data) && $stable(lcd_rs)
	);

endmodule

`default_nettype wire

/* design/lcd_pkg.sv */
`default_nettype none

package lcd_pkg;

	////////////////////////////////////////////////////////////////////////////
	// screen geometry
	////////////////////////////////////////////////////////////////////////////

	localparam int lcd_cols = 16;                     // characters per row.
	localparam int lcd_rows = 2;
	localparam int buf_depth = lcd_rows * lcd_cols;   // 32 entries.
	localparam int addr_w = $clog2(buf_depth);        // 5 bits.

	typedef logic [7:0] char_t;
	typedef logic [addr_w-1:0] addr_t;                // 0..15 row 1, 16..31 row 2.
	typedef logic [lcd_cols*8-1:0] row_t;             // leftmost char in top byte.

	localparam char_t blank_char = 8'h20;             // ascii space.

	////////////////////////////////////////////////////////////////////////////
	// HD44780 command bytes
	////////////////////////////////////////////////////////////////////////////

	localparam char_t cmd_function_set = 8'h38;       // 8-bit bus, 2 lines, 5x8 font.
	localparam char_t cmd_display_off = 8'h08;
	localparam char_t cmd_clear = 8'h01;
	localparam char_t cmd_entry_mode = 8'h06;         // increment, no shift.
	localparam char_t cmd_display_on = 8'h0C;         // no cursor, no blink.
	localparam char_t cmd_row1_addr = 8'h80;          // ddram 0x00.
	localparam char_t cmd_row2_addr = 8'hC0;          // ddram 0x40.

endpackage

`default_nettype wire

/* design/lcd_text_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lcd_text_top #(
	parameter int clk_div = 24000,
	parameter int fmt_base = 24
) (
	input  logic           clk,
	input  logic           rst,
	input  logic           host_we,
	input  lcd_pkg::addr_t host_addr,
	input  lcd_pkg::char_t host_char,
	input  logic           value_load,
	input  logic [31:0]    value,
	output logic           value_busy,
	output logic           lcd_en,
	output logic           lcd_rw,
	output logic           lcd_rs,
	output lcd_pkg::char_t lcd_data
);
	import lcd_pkg::*;

	logic  fmt_req;
	logic  fmt_gnt;
	addr_t fmt_addr;
	char_t fmt_char;
	logic  buf_we;
	addr_t buf_addr;
	char_t buf_char;
	row_t  row_1;
	row_t  row_2;

	////////////////////////////////////////////////////////////////////////////
	// write side
	////////////////////////////////////////////////////////////////////////////

	write_arbiter arb_i (
		.clk       (clk),
		.rst       (rst),
		.host_we   (host_we),
		.host_addr (host_addr),
		.host_char (host_char),
		.fmt_req   (fmt_req),
		.fmt_addr  (fmt_addr),
		.fmt_char  (fmt_char),
		.fmt_gnt   (fmt_gnt),
		.buf_we    (buf_we),
		.buf_addr  (buf_addr),
		.buf_char  (buf_char)
	);

	hex_formatter #(
		.fmt_base (fmt_base)
	) fmt_i (
		.clk        (clk),
		.rst        (rst),
		.value_load (value_load),
		.value      (value),
		.fmt_gnt    (fmt_gnt),
		.value_busy (value_busy),
		.fmt_req    (fmt_req),
		.fmt_addr   (fmt_addr),
		.fmt_char   (fmt_char)
	);

	char_buffer buf_i (
		.clk     (clk),
		.rst     (rst),
		.we      (buf_we),
		.addr    (buf_addr),
		.wr_char (buf_char),
		.row_1   (row_1),
		.row_2   (row_2)
	);

	////////////////////////////////////////////////////////////////////////////
	// display side
	////////////////////////////////////////////////////////////////////////////

	lcd1602 #(
		.clk_div (clk_div)
	) lcd_i (
		.clk      (clk),
		.rst      (rst),
		.row_1    (row_1),
		.row_2    (row_2),
		.lcd_en   (lcd_en),
		.lcd_rw   (lcd_rw),
		.lcd_rs   (lcd_rs),
		.lcd_data (lcd_data)
	);

endmodule

`default_nettype wire

/* design/write_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module write_arbiter (
	input  logic           clk,
	input  logic           rst,
	input  logic           host_we,
	input  lcd_pkg::addr_t host_addr,
	input  lcd_pkg::char_t host_char,
	input  logic           fmt_req,
	input  lcd_pkg::addr_t fmt_addr,
	input  lcd_pkg::char_t fmt_char,
	output logic           fmt_gnt,
	output logic           buf_we,
	output lcd_pkg::addr_t buf_addr,
	output lcd_pkg::char_t buf_char
);

	////////////////////////////////////////////////////////////////////////////
	// fixed priority select, host first
	////////////////////////////////////////////////////////////////////////////

	assign fmt_gnt = fmt_req & ~host_we;       // same-cycle grant.
	assign buf_we = host_we | fmt_req;

	always_comb begin
		if (host_we) begin
			buf_addr = host_addr;
			buf_char = host_char;
		end else begin
			buf_addr = fmt_addr;               // don't care when fmt_req is low.
			buf_char = fmt_char;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	a_host_first: assert property (
		@(posedge clk) disable iff (!rst)
		!(fmt_gnt && host_we)
	);

	a_gnt_needs_req: assert property (
		@(posedge clk) disable iff (!rst)
		fmt_gnt |-> fmt_req
	);

	// a formatter write that lost to the host is held unchanged
	a_req_held: assert property (
		@(posedge clk) disable iff (!rst)
		fmt_req && !fmt_gnt |=> fmt_req && $stable(fmt_addr) && $stable(fmt_char)
	);

endmodule

`default_nettype wire

/* lcd_text_top.f */
design/lcd_pkg.sv
design/char_buffer.sv
design/write_arbiter.sv
design/hex_formatter.sv
design/lcd1602.sv
design/lcd_text_top.sv
tb/lcd_text_tb.sv

/* tb/lcd_text_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module lcd_text_tb;

	localparam int clk_div = 8;
	localparam int fmt_base = 24;
	localparam int n_frames = 10;                // upper bound on frames in the run.
	localparam int limit_cycles = 16 + (10 + 6 + n_frames * 34) * clk_div + 200;
	localparam logic [7:0] row1_cmd = 8'h80;
	localparam logic [7:0] row2_cmd = 8'hC0;

	logic        clk;
	logic        rst;
	logic        host_we;
	logic [4:0]  host_addr;
	logic [7:0]  host_char;
	logic        value_load;
	logic [31:0] value;
	logic        value_busy;
	logic        lcd_en;
	logic        lcd_rw;
	logic        lcd_rs;
	logic [7:0]  lcd_data;

	logic [7:0]  model [32];                     // expected screen, row 1 then row 2.
	logic [7:0]  boot_bytes [6];
	logic        en_prev = 1'b1;                 // lcd_en is high through the start-up wait.
	integer      seed = 72110;
	int          errors;
	int          errors_base;
	int          n_pass;
	int          n_fail;
	logic        rs_q;
	logic [7:0]  data_q;
	logic [31:0] v;

	lcd_text_top #(
		.clk_div  (clk_div),
		.fmt_base (fmt_base)
	) dut_i (
		.clk        (clk),
		.rst        (rst),
		.host_we    (host_we),
		.host_addr  (host_addr),
		.host_char  (host_char),
		.value_load (value_load),
		.value      (value),
		.value_busy (value_busy),
		.lcd_en     (lcd_en),
		.lcd_rw     (lcd_rw),
		.lcd_rs     (lcd_rs),
		.lcd_data   (lcd_data)
	);

	always #10 clk = ~clk;

	always @(negedge clk) begin
		en_prev <= lcd_en;
	end

	initial begin
		#(limit_cycles * 20);
		$display("timeout: the run did not finish within %0d clock cycles", limit_cycles);
		$display("SOME TESTS FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [7:0] nibble_to_ascii(input logic [3:0] n);
		if (n < 4'd10) begin
			return 8'h30 + {4'h0, n};
		end
		return 8'h41 + {4'h0, n} - 8'd10;
	endfunction

	// waits for the next rising edge of lcd_en, sampled mid high phase.
	task automatic next_byte(output logic rs, output logic [7:0] data);
		do begin
			@(negedge clk);
		end while (!(lcd_en === 1'b1 && en_prev === 1'b0));
		rs = lcd_rs;
		data = lcd_data;
		assert (lcd_rw === 1'b0) else begin
			$display("MISMATCH lcd_rw: got %h expected %h", lcd_rw, 1'b0);
			errors++;
		end
	endtask

	task automatic expect_byte(input string what, input logic exp_rs, input logic [7:0] exp_d,
			input logic rs, input logic [7:0] d);
		assert (rs === exp_rs) else begin
			$display("MISMATCH lcd_rs at %s: got %h expected %h", what, rs, exp_rs);
			errors++;
		end
		assert (d === exp_d) else begin
			$display("MISMATCH lcd_data at %s: got %h expected %h", what, d, exp_d);
			errors++;
		end
	endtask

	task automatic check_frame(input string name);
		logic rs;
		logic [7:0] d;
		int n;
		n = 0;
		do begin
			next_byte(rs, d);
			n++;
		end while (!(rs === 1'b0 && d === row1_cmd) && n < 40);
		assert (rs === 1'b0 && d === row1_cmd) else begin
			$display("%s: no row 1 address command seen on the LCD bus", name);
			errors++;
		end
		for (int r = 0; r < 2; r++) begin
			if (r == 1) begin
				next_byte(rs, d);
				expect_byte("row 2 address", 1'b0, row2_cmd, rs, d);
			end
			for (int c = 0; c < 16; c++) begin
				next_byte(rs, d);
				expect_byte($sformatf("row %0d col %0d", r + 1, c), 1'b1, model[r * 16 + c],
					rs, d);
			end
		end
	endtask

	task automatic write_random(input int n, input int span);
		for (int i = 0; i < n; i++) begin
			@(negedge clk);
			host_we = 1'b1;
			host_addr = 5'($unsigned($random(seed)) % span);
			host_char = 8'($random(seed));
			model[host_addr] = host_char;        // last write to an address wins.
		end
		@(negedge clk);
		host_we = 1'b0;
	endtask

	// loads a value, optionally with a host write in each of the first cycles.
	task automatic format_value(input logic [31:0] val, input int n_host);
		int k;
		int busy_cnt;
		busy_cnt = 0;
		k = 0;
		@(negedge clk);
		value_load = 1'b1;
		value = val;
		do begin
			@(negedge clk);
			value_load = 1'b0;
			host_we = 1'b0;
			if (k == 0) begin
				assert (value_busy === 1'b1) else begin
					$display("value_busy did not rise the cycle after value_load");
					errors++;
				end
			end
			if (k < n_host) begin
				host_we = 1'b1;
				host_addr = 5'($unsigned($random(seed)) % fmt_base);
				host_char = 8'($random(seed));
				model[host_addr] = host_char;
			end
			if (n_host > 0 && k == 2) begin
				value_load = 1'b1;               // arrives while busy.
				value = $random(seed);
			end
			if (value_busy === 1'b1) begin
				busy_cnt++;
			end
			k++;
		end while ((value_busy === 1'b1 || k <= n_host) && k < 200);
		assert (value_busy === 1'b0) else begin
			$display("value_busy stayed high for %0d cycles and never fell", k);
			errors++;
		end
		assert (busy_cnt == 8 + n_host) else begin
			$display("MISMATCH value_busy cycles: got %h expected %h", busy_cnt, 8 + n_host);
			errors++;
		end
		for (int i = 0; i < 8; i++) begin
			model[fmt_base + i] = nibble_to_ascii(val[31 - 4 * i -: 4]);
		end
	endtask

	task automatic end_test(input int num, input string name);
		if (errors == errors_base) begin
			n_pass++;
			$display("test %0d %s: passed", num, name);
		end else begin
			n_fail++;
			$display("test %0d %s: failed with %0d errors", num, name, errors - errors_base);
		end
		errors_base = errors;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		clk = 1'b0;
		rst = 1'b0;
		host_we = 1'b0;
		host_addr = '0;
		host_char = '0;
		value_load = 1'b0;
		value = '0;
		errors = 0;
		errors_base = 0;
		n_pass = 0;
		n_fail = 0;
		boot_bytes = '{8'h38, 8'h08, 8'h01, 8'h06, 8'h0C, 8'h80};
		for (int i = 0; i < 32; i++) begin
			model[i] = 8'h20;                    // blank screen after reset.
		end
		repeat (16) @(negedge clk);
		rst = 1'b1;

		for (int i = 0; i < 6; i++) begin
			next_byte(rs_q, data_q);
			expect_byte($sformatf("start byte %0d", i), 1'b0, boot_bytes[i], rs_q, data_q);
		end
		end_test(1, "power-on command sequence");

		check_frame("blank frame");
		end_test(2, "blank frame after reset");

		write_random(20, 32);
		check_frame("host frame");
		end_test(3, "random host writes");

		v = $random(seed);
		format_value(v, 0);
		check_frame("hex frame");
		end_test(4, "value formatting");

		v = $random(seed);
		format_value(v, 12);
		check_frame("contention frame");
		end_test(5, "host and formatter contention");

		$display("tests: %0d passed, %0d failed, %0d check errors", n_pass, n_fail, errors);
		if (n_fail == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
